// File: verilog.f
+incdir+src
src/dcacheTypesPkg.sv
src/frameStore.sv
src/missController.sv
src/dcache.sv
verif/ramModel.sv
verif/dcacheTb.sv

// File: Makefile
# Verilator flow for the data cache

TB_TOP := dcacheTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall +incdir+src --top-module dcache \
	  src/dcacheTypesPkg.sv src/frameStore.sv src/missController.sv src/dcache.sv

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	  --top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP) | tee /dev/stderr | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

// File: verif/dcacheTb.sv
// Testbench for the data cache against a reference memory with random RAM latency
`timescale 1ns/1ps
`include "dcacheSettings.svh"

module dcacheTb;
  import dcacheTypesPkg::*;

  localparam int HALF_PERIOD   = 20;
  localparam int SAMPLE_DELAY  = 10;  // Mid low phase after drives settle
  localparam int HIT_TIMEOUT   = 100;
  localparam int FLUSH_TIMEOUT = 2000;
  localparam int OFF_BITS      = `DCACHE_INDEX_W + 3;

  logic        CLK;
  logic        rstN;
  cpuReq_t     cpuReq;
  logic        halt;
  logic        dhit;
  word_t       dmemload;
  logic        flushed;
  memReq_t     memReq;
  logic        dwait;
  word_t       dload;
  logic [31:0] peekAddr;
  word_t       peekData;
  int          readCount;
  int          writeCount;

  word_t       refMem [logic [31:0]];  // Last stored value per word
  bit          seen [logic [31:0]];
  logic [31:0] usedAddrs [$];          // Both words of every touched block
  string       testName = "reset";
  int          tests = 0;
  int          checks = 0;
  int          errors = 0;
  int          errorsAtStart = 0;
  bit          timedOut = 1'b0;

  dcache i_dut (
    .CLK      (CLK),
    .rstN     (rstN),
    .cpuReq   (cpuReq),
    .halt     (halt),
    .dhit     (dhit),
    .dmemload (dmemload),
    .flushed  (flushed),
    .memReq   (memReq),
    .dwait    (dwait),
    .dload    (dload)
  );

  ramModel i_ram (
    .CLK        (CLK),
    .rstN       (rstN),
    .memReq     (memReq),
    .dwait      (dwait),
    .dload      (dload),
    .peekAddr   (peekAddr),
    .peekData   (peekData),
    .readCount  (readCount),
    .writeCount (writeCount)
  );

  initial begin
    CLK = 1'b0;
    forever #(HALF_PERIOD) CLK = ~CLK;
  end

  function automatic logic [31:0] addrOf(input int tag, input int index, input int word);
    return (32'(tag) << OFF_BITS) | (32'(index) << 3) | (32'(word) << 2);
  endfunction

  // Expected word from the stored value or the RAM's initial pattern
  function automatic word_t expectedWord(input logic [31:0] a);
    logic [31:0] key;
    key = {a[31:2], 2'b00};
    if (refMem.exists(key)) begin
      return refMem[key];
    end
    return {key[15:0], key[31:16]} ^ 32'hC0DE_F00D;
  endfunction

  task automatic checkEq(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    assert (actual == expected) else begin
      $display("CHECK FAILED %s %s: expected 0x%08h actual 0x%08h",
               testName, what, expected, actual);
      errors++;
    end
  endtask

  // Load data against the reference on every load hit
  always begin
    @(negedge CLK);
    #(SAMPLE_DELAY);
    if (rstN && dhit && cpuReq.ren) begin
      checks++;
      assert (dmemload == expectedWord(cpuReq.addr)) else begin
        $display("CHECK FAILED %s load 0x%08h: expected 0x%08h actual 0x%08h",
                 testName, cpuReq.addr, expectedWord(cpuReq.addr), dmemload);
        errors++;
      end
    end
  end

  // Holds one request until dhit and counts the added cycles
  task automatic access(input bit isStore, input logic [31:0] addr, input word_t data,
                        output int cycles);
    logic [31:0] blk;
    cycles = 0;
    if (timedOut) return;
    blk = {addr[31:3], 3'b000};
    if (!seen.exists(blk)) begin
      seen[blk] = 1'b1;
      usedAddrs.push_back(blk);
      usedAddrs.push_back(blk | 32'h4);
    end
    @(negedge CLK);
    cpuReq.ren   = !isStore;
    cpuReq.wen   = isStore;
    cpuReq.addr  = addr;
    cpuReq.store = isStore ? data : '0;
    #(SAMPLE_DELAY);
    while (!dhit && cycles < HIT_TIMEOUT) begin
      @(negedge CLK);
      #(SAMPLE_DELAY);
      cycles++;
    end
    if (!dhit) begin
      $display("Timeout in %s: no dhit for request at 0x%08h", testName, addr);
      timedOut = 1'b1;
    end else if (isStore) begin
      refMem[{addr[31:2], 2'b00}] = data;  // Written on the coming edge
    end
  endtask

  task automatic peekRam(input logic [31:0] a, output word_t value);
    peekAddr = a;
    @(negedge CLK);
    #1;
    value = peekData;
  endtask

  task automatic startTest(input string name);
    testName      = name;
    errorsAtStart = errors;
    tests++;
  endtask

  task automatic reportTest();
    if (errors == errorsAtStart && !timedOut) begin
      $display("Test %-16s passed", testName);
    end else begin
      $display("Test %-16s failed, %0d errors", testName, errors - errorsAtStart);
    end
  endtask

  task automatic readMissTest();
    int cycles;
    int reads0;
    int writes0;
    startTest("readMiss");
    checkEq("flushed after reset", 32'h0, {31'b0, flushed});
    checkEq("memReq idle after reset", 32'h0, {31'b0, memReq.ren | memReq.wen});
    reads0  = readCount;
    writes0 = writeCount;
    access(1'b0, addrOf(5, 1, 0), '0, cycles);
    checkEq("block reads", 2, readCount - reads0);
    checkEq("writes", 0, writeCount - writes0);
    reportTest();
  endtask

  task automatic readHitTest();
    int cycles;
    int reads0;
    int writes0;
    startTest("readHit");
    reads0  = readCount;
    writes0 = writeCount;
    access(1'b0, addrOf(5, 1, 1), '0, cycles);
    checkEq("added cycles", 0, cycles);
    checkEq("memory requests", 0, (readCount - reads0) + (writeCount - writes0));
    reportTest();
  endtask

  task automatic storeTest();
    int cycles;
    startTest("store");
    access(1'b1, addrOf(5, 1, 0), 32'h1111_2222, cycles);  // Present block
    checkEq("store hit cycles", 0, cycles);
    access(1'b1, addrOf(9, 2, 1), 32'h3333_4444, cycles);  // Allocates first
    access(1'b0, addrOf(5, 1, 0), '0, cycles);
    access(1'b0, addrOf(9, 2, 1), '0, cycles);
    access(1'b0, addrOf(9, 2, 0), '0, cycles);  // Fetched neighbour word
    reportTest();
  endtask

  task automatic evictionTest();
    int    cycles;
    int    reads0;
    int    writes0;
    word_t value;
    startTest("dirtyEviction");
    access(1'b1, addrOf(20, 4, 0), 32'hD1D1_0001, cycles);
    access(1'b0, addrOf(21, 4, 1), '0, cycles);  // Tag 20 becomes the older way
    reads0  = readCount;
    writes0 = writeCount;
    access(1'b0, addrOf(22, 4, 0), '0, cycles);
    checkEq("write-backs", 2, writeCount - writes0);
    checkEq("fetch reads", 2, readCount - reads0);
    peekRam(addrOf(20, 4, 0), value);
    checkEq("written back word 0", 32'hD1D1_0001, value);
    peekRam(addrOf(20, 4, 1), value);
    checkEq("written back word 1", expectedWord(addrOf(20, 4, 1)), value);
    access(1'b0, addrOf(20, 4, 0), '0, cycles);
    reportTest();
  endtask

  task automatic randomMixTest();
    int          idxList [4] = '{0, 3, 5, 6};
    int          cycles;
    int          i;
    logic [31:0] addr;
    startTest("randomMix");
    for (i = 0; i < 300; i++) begin
      addr = addrOf(40 + int'($urandom % 8), idxList[$urandom % 4], int'($urandom % 2));
      access(($urandom % 2) == 1, addr, $urandom, cycles);
    end
    reportTest();
  endtask

  task automatic flushTest();
    int    n;
    word_t value;
    startTest("haltFlush");
    if (!timedOut) begin
      @(negedge CLK);
      cpuReq = '0;
      halt   = 1'b1;
      #(SAMPLE_DELAY);
      n = 0;
      while (!flushed && n < FLUSH_TIMEOUT) begin
        @(negedge CLK);
        #(SAMPLE_DELAY);
        n++;
      end
      if (!flushed) begin
        $display("Timeout in %s: flushed never rose after halt", testName);
        timedOut = 1'b1;
      end else begin
        checkEq("memReq idle", 32'h0, {31'b0, memReq.ren | memReq.wen});
        foreach (usedAddrs[k]) begin
          peekRam(usedAddrs[k], value);
          checkEq($sformatf("RAM 0x%08h", usedAddrs[k]), expectedWord(usedAddrs[k]), value);
        end
      end
    end
    reportTest();
  endtask

  initial begin
    void'($urandom(39316));
    rstN     = 1'b0;
    halt     = 1'b0;
    cpuReq   = '0;
    peekAddr = '0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    rstN = 1'b1;
    readMissTest();
    readHitTest();
    storeTest();
    evictionTest();
    randomMixTest();
    flushTest();
    $display("Tests %0d, checks %0d, errors %0d, timeout %0d",
             tests, checks, errors, timedOut);
    if (errors == 0 && !timedOut) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: verif/ramModel.sv
// Behavioral word memory that answers cache requests after random dwait stretches
`timescale 1ns/1ps

module ramModel (
  input  logic                    CLK,
  input  logic                    rstN,
  input  dcacheTypesPkg::memReq_t memReq,
  output logic                    dwait,
  output dcacheTypesPkg::word_t   dload,
  input  logic [31:0]             peekAddr,
  output dcacheTypesPkg::word_t   peekData,
  output int                      readCount,
  output int                      writeCount
);
  import dcacheTypesPkg::*;

  word_t       mem [logic [31:0]];  // Only written words are kept
  int          stallLeft;           // Below zero while no request is served
  logic [31:0] reqAddr;

  // Word that was never written
  function automatic word_t wordAt(input logic [31:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return {a[15:0], a[31:16]} ^ 32'hC0DE_F00D;  // Depends on every address bit
  endfunction

  initial begin
    dwait      = 1'b1;
    dload      = '0;
    peekData   = '0;
    readCount  = 0;
    writeCount = 0;
    stallLeft  = -1;
  end

  always @(negedge CLK) begin
    peekData <= wordAt(peekAddr);  // Backdoor view for the testbench
    if (!rstN || !(memReq.ren || memReq.wen)) begin
      dwait     <= 1'b1;
      stallLeft = -1;
    end else if (stallLeft < 0) begin
      dwait     <= 1'b1;  // New request, first busy cycle
      stallLeft = $urandom_range(4, 1) - 1;
    end else if (stallLeft > 0) begin
      dwait     <= 1'b1;
      stallLeft = stallLeft - 1;
    end else begin
      // Request completes on the coming rising edge
      reqAddr       = memReq.addr;
      reqAddr[1:0]  = 2'b00;
      dwait         <= 1'b0;
      if (memReq.wen) begin
        mem[reqAddr] = memReq.store;
        writeCount   <= writeCount + 1;
      end else begin
        dload     <= wordAt(reqAddr);
        readCount <= readCount + 1;
      end
      stallLeft = -1;
    end
  end

endmodule

// File: src/dcache.sv
// Write-back two-way data cache between the datapath and a word memory
`timescale 1ns/1ps

module dcache (
  input  logic                    CLK,
  input  logic                    rstN,
  input  dcacheTypesPkg::cpuReq_t cpuReq,
  input  logic                    halt,
  output logic                    dhit,
  output dcacheTypesPkg::word_t   dmemload,
  output logic                    flushed,
  output dcacheTypesPkg::memReq_t memReq,
  input  logic                    dwait,
  input  dcacheTypesPkg::word_t   dload
);
  import dcacheTypesPkg::*;

  // Controller to frame store
  dcacheAddr_t lookupAddr;
  logic        writeWord;
  word_t       writeData;
  logic        fillWord;
  word_t       fillData;
  logic        touch;
  logic        cleanVictim;
  logic        scanWay;
  logic        useScan;

  // Frame store to controller
  logic        hit;
  frame_t      victim;

  frameStore i_frameStore (
    .CLK         (CLK),
    .rstN        (rstN),
    .lookupAddr  (lookupAddr),
    .writeWord   (writeWord),
    .writeData   (writeData),
    .fillWord    (fillWord),
    .fillData    (fillData),
    .touch       (touch),
    .cleanVictim (cleanVictim),
    .scanWay     (scanWay),
    .useScan     (useScan),
    .hit         (hit),
    .hitData     (dmemload),  // Load data valid with dhit
    .victim      (victim)
  );

  missController i_missController (
    .CLK         (CLK),
    .rstN        (rstN),
    .cpuReq      (cpuReq),
    .halt        (halt),
    .hit         (hit),
    .victim      (victim),
    .dwait       (dwait),
    .dload       (dload),
    .lookupAddr  (lookupAddr),
    .writeWord   (writeWord),
    .writeData   (writeData),
    .fillWord    (fillWord),
    .fillData    (fillData),
    .touch       (touch),
    .cleanVictim (cleanVictim),
    .scanWay     (scanWay),
    .useScan     (useScan),
    .memReq      (memReq),
    .dhit        (dhit),
    .flushed     (flushed)
  );

endmodule

// File: src/missController.sv
// Data cache controller for hits, write-back, block fill and halt flush
`timescale 1ns/1ps
`include "dcacheSettings.svh"

module missController (
  input  logic                         CLK,
  input  logic                         rstN,
  input  dcacheTypesPkg::cpuReq_t      cpuReq,
  input  logic                         halt,
  input  logic                         hit,
  input  dcacheTypesPkg::frame_t       victim,
  input  logic                         dwait,
  input  dcacheTypesPkg::word_t        dload,
  output dcacheTypesPkg::dcacheAddr_t  lookupAddr,
  output logic                         writeWord,
  output dcacheTypesPkg::word_t        writeData,
  output logic                         fillWord,
  output dcacheTypesPkg::word_t        fillData,
  output logic                         touch,
  output logic                         cleanVictim,
  output logic                         scanWay,
  output logic                         useScan,
  output dcacheTypesPkg::memReq_t      memReq,
  output logic                         dhit,
  output logic                         flushed
);
  import dcacheTypesPkg::*;

  cacheState_t state;
  cacheState_t nextState;

  // Flush position as {done, set, way}
  logic [`DCACHE_INDEX_W+1:0] flushCnt;
  logic                       flushStep;
  dcacheIndex_t               scanIndex;
  logic                       reqValid;
  logic                       victimDirty;

  // Word aligned address of one word in a block
  function automatic dcacheAddr_t blockAddr(input dcacheTag_t tag,
                                            input dcacheIndex_t index,
                                            input logic blkOff);
    dcacheAddr_t a;
    a.tag     = tag;
    a.index   = index;
    a.blkOff  = blkOff;
    a.byteOff = 2'b00;
    return a;
  endfunction

  assign scanIndex   = flushCnt[`DCACHE_INDEX_W:1];
  assign scanWay     = flushCnt[0];
  assign reqValid    = cpuReq.ren || cpuReq.wen;
  assign victimDirty = victim.valid && victim.dirty;
  assign writeData   = cpuReq.store;
  assign fillData    = dload;
  assign flushed     = (state == stFlushed);  // Held until reset

  // Frame lookup depends only on state, so no loop through the frame store
  always_comb begin
    lookupAddr = cpuReq.addr;
    useScan    = 1'b0;
    unique case (state)
      stFetch0:
        lookupAddr = blockAddr(cpuReq.addr.tag, cpuReq.addr.index, 1'b0);
      stFetch1:
        lookupAddr = blockAddr(cpuReq.addr.tag, cpuReq.addr.index, 1'b1);
      stFlushScan, stFlushWb0, stFlushWb1: begin
        lookupAddr = blockAddr('0, scanIndex, 1'b0);  // Tag unused in scan
        useScan    = 1'b1;
      end
      default: ;
    endcase
  end

  always_comb begin
    nextState   = state;
    writeWord   = 1'b0;
    fillWord    = 1'b0;
    touch       = 1'b0;
    cleanVictim = 1'b0;
    flushStep   = 1'b0;
    dhit        = 1'b0;
    memReq      = '0;
    unique case (state)
      stIdle: begin
        if (halt) begin
          nextState = stFlushScan;  // Pending request is dropped
        end else if (reqValid) begin
          if (hit) begin
            dhit      = 1'b1;
            writeWord = cpuReq.wen;
            touch     = 1'b1;
          end else if (victimDirty) begin
            nextState = stWriteBack0;
          end else begin
            nextState = stFetch0;
          end
        end
      end
      stWriteBack0: begin
        memReq.wen   = 1'b1;
        memReq.addr  = blockAddr(victim.tag, cpuReq.addr.index, 1'b0);
        memReq.store = victim.data[0];
        if (!dwait) begin
          nextState = stWriteBack1;
        end
      end
      stWriteBack1: begin
        memReq.wen   = 1'b1;
        memReq.addr  = blockAddr(victim.tag, cpuReq.addr.index, 1'b1);
        memReq.store = victim.data[1];
        if (!dwait) begin
          cleanVictim = 1'b1;
          nextState   = stFetch0;
        end
      end
      stFetch0: begin
        memReq.ren  = 1'b1;
        memReq.addr = lookupAddr;
        if (!dwait) begin
          fillWord  = 1'b1;
          nextState = stFetch1;
        end
      end
      stFetch1: begin
        memReq.ren  = 1'b1;
        memReq.addr = lookupAddr;
        if (!dwait) begin
          fillWord  = 1'b1;
          touch     = 1'b1;  // New block is most recent
          nextState = stIdle;
        end
      end
      stFlushScan: begin
        if (flushCnt[`DCACHE_INDEX_W+1]) begin
          nextState = stFlushed;  // Walked every set and way
        end else if (victimDirty) begin
          nextState = stFlushWb0;
        end else begin
          flushStep = 1'b1;
        end
      end
      stFlushWb0: begin
        memReq.wen   = 1'b1;
        memReq.addr  = blockAddr(victim.tag, scanIndex, 1'b0);
        memReq.store = victim.data[0];
        if (!dwait) begin
          nextState = stFlushWb1;
        end
      end
      stFlushWb1: begin
        memReq.wen   = 1'b1;
        memReq.addr  = blockAddr(victim.tag, scanIndex, 1'b1);
        memReq.store = victim.data[1];
        if (!dwait) begin
          cleanVictim = 1'b1;
          flushStep   = 1'b1;
          nextState   = stFlushScan;
        end
      end
      stFlushed: ;  // Wait here for reset
      default:
        nextState = stIdle;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      state    <= stIdle;
      flushCnt <= '0;
    end else begin
      state <= nextState;
      if (flushStep) begin
        flushCnt <= flushCnt + 1'b1;
      end
    end
  end

endmodule

// File: src/frameStore.sv
// Two-way set associative frame storage with tag compare and LRU victim choice
`timescale 1ns/1ps
`include "dcacheSettings.svh"

module frameStore (
  input  logic                        CLK,
  input  logic                        rstN,
  input  dcacheTypesPkg::dcacheAddr_t lookupAddr,
  input  logic                        writeWord,
  input  dcacheTypesPkg::word_t       writeData,
  input  logic                        fillWord,
  input  dcacheTypesPkg::word_t       fillData,
  input  logic                        touch,
  input  logic                        cleanVictim,
  input  logic                        scanWay,
  input  logic                        useScan,
  output logic                        hit,
  output dcacheTypesPkg::word_t       hitData,
  output dcacheTypesPkg::frame_t      victim
);
  import dcacheTypesPkg::*;

  dcacheTag_t              tagMem  [2][`DCACHE_SETS];
  word_t                   dataMem [2][`DCACHE_SETS][2];
  logic [`DCACHE_SETS-1:0] validBits [2];
  logic [`DCACHE_SETS-1:0] dirtyBits [2];
  logic [`DCACHE_SETS-1:0] lruBits;  // Least recently used way per set

  dcacheIndex_t idx;
  logic [1:0]   wayHit;
  logic         hitWay;
  logic         victimWay;
  logic         touchWay;

  assign idx = lookupAddr.index;

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = validBits[w][idx] && (tagMem[w][idx] == lookupAddr.tag);
    end
  end

  assign hit     = |wayHit;
  assign hitWay  = wayHit[1];  // Both ways never hold the same tag
  assign hitData = dataMem[hitWay][idx][lookupAddr.blkOff];

  // Empty way first, then the older one
  always_comb begin
    if (useScan) begin
      victimWay = scanWay;  // Flush walks ways in order
    end else if (!validBits[0][idx]) begin
      victimWay = 1'b0;
    end else if (!validBits[1][idx]) begin
      victimWay = 1'b1;
    end else begin
      victimWay = lruBits[idx];
    end
  end

  always_comb begin
    victim.valid   = validBits[victimWay][idx];
    victim.dirty   = dirtyBits[victimWay][idx];
    victim.tag     = tagMem[victimWay][idx];
    victim.data[0] = dataMem[victimWay][idx][0];
    victim.data[1] = dataMem[victimWay][idx][1];
  end

  assign touchWay = hit ? hitWay : victimWay;

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      for (int w = 0; w < 2; w++) begin
        validBits[w] <= '0;
        dirtyBits[w] <= '0;
      end
      lruBits <= '0;
    end else begin
      if (writeWord && hit) begin
        dirtyBits[hitWay][idx] <= 1'b1;
      end
      if (fillWord) begin
        // Frame stays invalid until the second word lands
        validBits[victimWay][idx] <= lookupAddr.blkOff;
        dirtyBits[victimWay][idx] <= 1'b0;
      end
      if (cleanVictim) begin
        dirtyBits[victimWay][idx] <= 1'b0;  // Written back to RAM
      end
      if (touch) begin
        lruBits[idx] <= ~touchWay;  // Other way becomes the older one
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (writeWord && hit) begin
      dataMem[hitWay][idx][lookupAddr.blkOff] <= writeData;
    end
    if (fillWord) begin
      dataMem[victimWay][idx][lookupAddr.blkOff] <= fillData;
      tagMem[victimWay][idx] <= lookupAddr.tag;
    end
  end

endmodule

// File: src/dcacheTypesPkg.sv
// Data cache types for address fields, requests, frames and controller states
`include "dcacheSettings.svh"

package dcacheTypesPkg;

  typedef logic [`DCACHE_WORD_W-1:0] word_t;
  typedef logic [`DCACHE_TAG_W-1:0] dcacheTag_t;
  typedef logic [`DCACHE_INDEX_W-1:0] dcacheIndex_t;

  typedef struct packed {
    dcacheTag_t   tag;
    dcacheIndex_t index;
    logic         blkOff;   // Word select within block
    logic [1:0]   byteOff;  // Ignored, word access only
  } dcacheAddr_t;

  // Datapath side request, held until dhit
  typedef struct packed {
    logic        ren;
    logic        wen;
    dcacheAddr_t addr;
    word_t       store;
  } cpuReq_t;

  // RAM side request, done when dwait is low
  typedef struct packed {
    logic        ren;
    logic        wen;
    dcacheAddr_t addr;
    word_t       store;
  } memReq_t;

  typedef struct packed {
    logic       valid;
    logic       dirty;
    dcacheTag_t tag;
    word_t [1:0] data;  // Indexed by blkOff
  } frame_t;

  typedef enum logic [3:0] {
    stIdle,
    stWriteBack0,
    stWriteBack1,
    stFetch0,
    stFetch1,
    stFlushScan,
    stFlushWb0,
    stFlushWb1,
    stFlushed
  } cacheState_t;

endpackage

// File: src/dcacheSettings.svh
// Data cache geometry and data width macros
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Set count and its log2, kept in step by hand
`define DCACHE_SETS 8
`define DCACHE_INDEX_W 3

// Datapath widths
`define DCACHE_WORD_W 32
`define DCACHE_ADDR_W 32

// Offsets inside an address
`define DCACHE_BLK_OFF_W 1
`define DCACHE_BYTE_OFF_W 2

// Whatever is left of the address after index and offsets
`define DCACHE_TAG_W \
  (`DCACHE_ADDR_W - `DCACHE_INDEX_W - `DCACHE_BLK_OFF_W - `DCACHE_BYTE_OFF_W)

`endif
